// File: afifo.f
+incdir+src
src/afifo_ptr_pkg.sv
src/afifo_mem_pkg.sv
src/afifo_sync_stages.sv
src/afifo_wr_ptr_full.sv
src/afifo_rd_ptr_empty.sv
src/afifo_ram_dp_2clk.sv
src/afifo.sv
tests/afifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FIFO testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module afifo_tb -f afifo.f

output=$(./obj_dir/Vafifo_tb 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Testbench passed"

// File: tests/afifo_tb.sv
// Directed tests for the dual-clock FIFO check it against a queue model.
// The write clock runs at 10 ns and the read clock at 14 ns. Sizes come from afifo_settings.svh.
`timescale 1ns/1ns
`default_nettype none

`include "afifo_settings.svh"

module afifo_tb;

    localparam int W           = `AFIFO_WIDTH;
    localparam int RAND_CYCLES = 300;
    // Rough sum of the test lengths with slack for flag latency.
    localparam int RUN_NS = 1000 + `AFIFO_DEPTH * (`AFIFO_CDC_STAGES + 6) * 28
                          + RAND_CYCLES * 10;

    logic         wr_clk_i;
    logic         rd_clk_i;
    logic         rst_n_i;
    logic [W-1:0] wr_data_i;
    logic         push_i;
    logic         pop_i;
    logic [W-1:0] rd_data_o;
    logic         full_o;
    logic         a_full_o;
    logic         empty_o;
    logic         a_empty_o;

    logic [W-1:0] model [$]; // Words the FIFO holds with the oldest first.
    logic [15:0]  lfsr = 16'd6;
    int           checks = 0;
    int           errors = 0;

    afifo dut (
        .wr_clk_i (wr_clk_i),
        .rd_clk_i (rd_clk_i),
        .rst_n_i  (rst_n_i),
        .wr_data_i(wr_data_i),
        .push_i   (push_i),
        .pop_i    (pop_i),
        .rd_data_o(rd_data_o),
        .full_o   (full_o),
        .a_full_o (a_full_o),
        .empty_o  (empty_o),
        .a_empty_o(a_empty_o)
    );

    initial begin
        wr_clk_i = 1'b0;
        forever #5 wr_clk_i = ~wr_clk_i;
    end

    initial begin
        rd_clk_i = 1'b0;
        forever #7 rd_clk_i = ~rd_clk_i;
    end

    // Taps 16, 14, 13 and 11.
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [W-1:0] rand_word();
        logic [W-1:0] word;
        for (int i = 0; i < W; i++) begin
            word[i] = next_bit();
        end
        return word;
    endfunction

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic wait_idle();
        repeat (`AFIFO_CDC_STAGES + 4) @(posedge rd_clk_i);
    endtask

    task automatic check_reset_state();
        @(negedge wr_clk_i);
        expect_true(empty_o && a_empty_o, "empty flags low after reset");
        expect_true(!full_o && !a_full_o, "full flags high after reset");
        expect_true(rd_data_o == '0, "rd_data_o not zero after reset");
    endtask

    // Flags are exact here because the read pointer has settled.
    task automatic check_wr_flags();
        expect_true(a_full_o == (model.size() >= `AFIFO_DEPTH - `AFIFO_AFULL_MARGIN),
                    $sformatf("a_full_o is %b at level %0d", a_full_o, model.size()));
        expect_true(full_o == (model.size() == `AFIFO_DEPTH),
                    $sformatf("full_o is %b at level %0d", full_o, model.size()));
    endtask

    // The last pass drops push_i and commits the final word.
    task automatic push_burst(input int n, input logic [W-1:0] base, input logic check_flags);
        for (int i = 0; i <= n; i++) begin
            @(posedge wr_clk_i);
            push_i    <= (i < n);
            wr_data_i <= base + W'(i);
            @(negedge wr_clk_i);
            if (check_flags) begin
                check_wr_flags();
            end
            if (push_i && !full_o) begin
                model.push_back(wr_data_i);
            end
        end
    endtask

    task automatic pop_check(input int settle);
        logic [W-1:0] expected;
        @(posedge rd_clk_i);
        pop_i <= 1'b1;
        @(negedge rd_clk_i);
        while (empty_o) begin
            @(negedge rd_clk_i);
        end
        expected = model.pop_front();
        @(posedge rd_clk_i);
        pop_i <= 1'b0;
        @(negedge rd_clk_i);
        expect_true(rd_data_o == expected,
                    $sformatf("rd_data_o %h, expected %h", rd_data_o, expected));
        if (model.size() == 0) begin
            expect_true(empty_o, "empty_o low after the last word was popped");
        end
        repeat (settle) @(negedge rd_clk_i);
        if (settle > 0) begin
            expect_true(a_empty_o == (model.size() <= `AFIFO_AEMPTY_MARGIN),
                        $sformatf("a_empty_o is %b at level %0d", a_empty_o, model.size()));
        end
    endtask

    task automatic extra_pops();
        logic [W-1:0] held;
        @(negedge rd_clk_i);
        held = rd_data_o;
        @(posedge rd_clk_i);
        pop_i <= 1'b1;
        repeat (4) @(posedge rd_clk_i);
        pop_i <= 1'b0;
        @(negedge rd_clk_i);
        expect_true(rd_data_o == held, "rd_data_o changed on a pop while empty");
        expect_true(empty_o && a_empty_o, "empty flags dropped on a pop while empty");
    endtask

    task automatic write_random();
        logic full_seen = 1'b0;
        repeat (RAND_CYCLES) begin
            @(posedge wr_clk_i);
            push_i    <= next_bit() && !full_seen;
            wr_data_i <= rand_word();
            @(negedge wr_clk_i);
            if (push_i && !full_o) begin
                model.push_back(wr_data_i);
            end
            full_seen = full_o;
        end
        @(posedge wr_clk_i);
        push_i <= 1'b0;
    endtask

    task automatic read_random();
        logic         empty_seen = 1'b1;
        logic         pending = 1'b0;
        logic [W-1:0] expected = '0;
        for (int i = 0; i <= RAND_CYCLES * 10 / 14; i++) begin
            @(posedge rd_clk_i);
            pop_i <= (i < RAND_CYCLES * 10 / 14) && next_bit() && !empty_seen;
            @(negedge rd_clk_i);
            if (pending) begin  // Data of the pop committed at this cycle's edge.
                expect_true(rd_data_o == expected,
                            $sformatf("rd_data_o %h, expected %h", rd_data_o, expected));
            end
            pending = pop_i && !empty_o;
            if (pending) begin
                expected = model.pop_front();
            end
            empty_seen = empty_o;
        end
    endtask

    initial begin
        rst_n_i   = 1'b0;
        push_i    = 1'b0;
        pop_i     = 1'b0;
        wr_data_i = '0;
        repeat (2) @(posedge wr_clk_i);
        rst_n_i <= 1'b1;
        check_reset_state();

        push_burst(5, rand_word(), 1'b0);
        @(negedge rd_clk_i);
        while (empty_o) begin
            @(negedge rd_clk_i);
        end
        repeat (5) pop_check(0);
        wait_idle();

        push_burst(`AFIFO_DEPTH + 3, rand_word(), 1'b1); // Last three are dropped.
        expect_true(model.size() == `AFIFO_DEPTH, "accepted pushes differ from the depth");
        wait_idle();
        repeat (`AFIFO_DEPTH) pop_check(`AFIFO_CDC_STAGES + 2);
        extra_pops();
        wait_idle();

        fork
            write_random();
            read_random();
        join
        while (model.size() > 0) begin
            pop_check(0);
        end
        wait_idle();
        expect_true(empty_o, "FIFO not empty once the model drained");

        $display("Summary: %0d checks, %0d errors.", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_NS);
        $display("Watchdog: the tests did not finish within %0d ns.", 2 * RUN_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/afifo.sv
// Dual-clock FIFO top level.
// rst_n_i resets both domains directly and must span several cycles of each clock.
// Pushes while full_o is high are dropped. Pops while empty_o is high are ignored.
`timescale 1ns/1ns
`default_nettype none

`include "afifo_settings.svh"

module afifo #(
    parameter afifo_mem_pkg::mem_style_e MEM_STYLE = afifo_mem_pkg::MEM_BLOCK
) (
    input  logic                    wr_clk_i,
    input  logic                    rd_clk_i,
    input  logic                    rst_n_i,
    input  logic [`AFIFO_WIDTH-1:0] wr_data_i,
    input  logic                    push_i,
    input  logic                    pop_i,
    output logic [`AFIFO_WIDTH-1:0] rd_data_o,
    output logic                    full_o,
    output logic                    a_full_o,
    output logic                    empty_o,
    output logic                    a_empty_o
);

    localparam int ADDR_WIDTH = $clog2(`AFIFO_DEPTH);

    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH:0]   wr_ptr_gray;
    logic [ADDR_WIDTH:0]   wr_ptr_sync; // Write pointer seen in the read domain.

    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH:0]   rd_ptr_gray;
    logic [ADDR_WIDTH:0]   rd_ptr_sync; // Read pointer seen in the write domain.

    afifo_wr_ptr_full u_wr_ptr_full (
        .wr_clk_i     (wr_clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push_i),
        .rd_ptr_sync_i(rd_ptr_sync),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_ptr_gray_o(wr_ptr_gray),
        .full_o       (full_o),
        .a_full_o     (a_full_o)
    );

    afifo_rd_ptr_empty u_rd_ptr_empty (
        .rd_clk_i     (rd_clk_i),
        .rst_n_i      (rst_n_i),
        .pop_i        (pop_i),
        .wr_ptr_sync_i(wr_ptr_sync),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .rd_ptr_gray_o(rd_ptr_gray),
        .empty_o      (empty_o),
        .a_empty_o    (a_empty_o)
    );

    afifo_ram_dp_2clk #(
        .MEM_WIDTH(`AFIFO_WIDTH),
        .MEM_DEPTH(`AFIFO_DEPTH),
        .MEM_STYLE(MEM_STYLE)
    ) u_ram (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data_i),
        .rd_clk_i (rd_clk_i),
        .rst_n_i  (rst_n_i),
        .rd_en_i  (rd_en),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data_o)
    );

    afifo_sync_stages #(
        .DATA_WIDTH(ADDR_WIDTH + 1),
        .STAGES    (`AFIFO_CDC_STAGES)
    ) u_wr2rd_sync (
        .clk_i  (rd_clk_i),
        .rst_n_i(rst_n_i),
        .data_i (wr_ptr_gray),
        .data_o (wr_ptr_sync)
    );

    afifo_sync_stages #(
        .DATA_WIDTH(ADDR_WIDTH + 1),
        .STAGES    (`AFIFO_CDC_STAGES)
    ) u_rd2wr_sync (
        .clk_i  (wr_clk_i),
        .rst_n_i(rst_n_i),
        .data_i (rd_ptr_gray),
        .data_o (rd_ptr_sync)
    );

endmodule

`default_nettype wire

// File: src/afifo_ram_dp_2clk.sv
// Simple dual-port RAM, write port and read port on separate clocks.
// Read data is registered and loads only when rd_en_i is high.
`timescale 1ns/1ns
`default_nettype none

module afifo_ram_dp_2clk #(
    parameter int                       MEM_WIDTH = 32,
    parameter int                       MEM_DEPTH = 16,
    parameter afifo_mem_pkg::mem_style_e MEM_STYLE = afifo_mem_pkg::MEM_BLOCK
) (
    input  logic                         wr_clk_i,
    input  logic                         wr_en_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] wr_addr_i,
    input  logic [MEM_WIDTH-1:0]         wr_data_i,
    input  logic                         rd_clk_i,
    input  logic                         rst_n_i,
    input  logic                         rd_en_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr_i,
    output logic [MEM_WIDTH-1:0]         rd_data_o
);

    localparam string RAM_STYLE =
        (MEM_STYLE == afifo_mem_pkg::MEM_BLOCK) ? "block" : "distributed";

    (* ram_style = RAM_STYLE *)
    logic [MEM_WIDTH-1:0] mem [MEM_DEPTH];

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output register holds its word until the next accepted pop.
    always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: src/afifo_rd_ptr_empty.sv
// Read pointer and empty flags live in the read clock domain.
// Flags are registered from the next pointer and may stay set longer than needed.
`timescale 1ns/1ns
`default_nettype none

`include "afifo_settings.svh"

module afifo_rd_ptr_empty (
    input  logic                            rd_clk_i,
    input  logic                            rst_n_i,
    input  logic                            pop_i,
    input  logic [$clog2(`AFIFO_DEPTH):0]   wr_ptr_sync_i,
    output logic                            rd_en_o,
    output logic [$clog2(`AFIFO_DEPTH)-1:0] rd_addr_o,
    output logic [$clog2(`AFIFO_DEPTH):0]   rd_ptr_gray_o,
    output logic                            empty_o,
    output logic                            a_empty_o
);

    localparam int ADDR_WIDTH = $clog2(`AFIFO_DEPTH);
    localparam logic [ADDR_WIDTH:0] AEMPTY_LEVEL =
        (ADDR_WIDTH + 1)'(`AFIFO_AEMPTY_MARGIN);

    logic [ADDR_WIDTH:0] rd_bin;
    logic [ADDR_WIDTH:0] rd_gray;
    logic [ADDR_WIDTH:0] rd_bin_next;
    logic [ADDR_WIDTH:0] rd_gray_next;
    logic [ADDR_WIDTH:0] level_next;

    assign rd_en_o      = pop_i & ~empty_o;
    assign rd_bin_next  = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_en_o};
    assign rd_gray_next = afifo_ptr_pkg::bin2gray(rd_bin_next);

    // Level seen from the read side after this cycle's pop.
    assign level_next = afifo_ptr_pkg::gray2bin(wr_ptr_sync_i) - rd_bin_next;

    always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            empty_o   <= 1'b1;
            a_empty_o <= 1'b1;
        end else begin
            rd_bin    <= rd_bin_next;
            rd_gray   <= rd_gray_next;
            empty_o   <= (rd_gray_next == wr_ptr_sync_i); // Caught up with the writer.
            a_empty_o <= (level_next <= AEMPTY_LEVEL);
        end
    end

    assign rd_addr_o     = rd_bin[ADDR_WIDTH-1:0];
    assign rd_ptr_gray_o = rd_gray;

    // The write side synchronizer relies on single-bit steps.
    a_rd_gray_step: assert property (@(posedge rd_clk_i) disable iff (!rst_n_i)
        $countones(rd_gray ^ $past(rd_gray)) <= 1);

    // A pop on an empty FIFO would wrap the level past the depth.
    a_no_read_empty: assert property (@(posedge rd_clk_i) disable iff (!rst_n_i)
        level_next <= (ADDR_WIDTH + 1)'(`AFIFO_DEPTH));

endmodule

`default_nettype wire

// File: src/afifo_wr_ptr_full.sv
// Write pointer and full flags live in the write clock domain.
// Flags are registered from the next pointer and may stay set longer than needed.
`timescale 1ns/1ns
`default_nettype none

`include "afifo_settings.svh"

module afifo_wr_ptr_full (
    input  logic                            wr_clk_i,
    input  logic                            rst_n_i,
    input  logic                            push_i,
    input  logic [$clog2(`AFIFO_DEPTH):0]   rd_ptr_sync_i,
    output logic                            wr_en_o,
    output logic [$clog2(`AFIFO_DEPTH)-1:0] wr_addr_o,
    output logic [$clog2(`AFIFO_DEPTH):0]   wr_ptr_gray_o,
    output logic                            full_o,
    output logic                            a_full_o
);

    localparam int ADDR_WIDTH = $clog2(`AFIFO_DEPTH);
    localparam logic [ADDR_WIDTH:0] AFULL_LEVEL =
        (ADDR_WIDTH + 1)'(`AFIFO_DEPTH - `AFIFO_AFULL_MARGIN);

    logic [ADDR_WIDTH:0] wr_bin;
    logic [ADDR_WIDTH:0] wr_gray;
    logic [ADDR_WIDTH:0] wr_bin_next;
    logic [ADDR_WIDTH:0] wr_gray_next;
    logic [ADDR_WIDTH:0] rd_ptr_wrapped;
    logic [ADDR_WIDTH:0] level_next;

    assign wr_en_o      = push_i & ~full_o;
    assign wr_bin_next  = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_en_o};
    assign wr_gray_next = afifo_ptr_pkg::bin2gray(wr_bin_next);

    // A gray pointer one lap ahead differs only in its top two bits.
    assign rd_ptr_wrapped = {~rd_ptr_sync_i[ADDR_WIDTH:ADDR_WIDTH-1],
                             rd_ptr_sync_i[ADDR_WIDTH-2:0]};
    assign level_next     = wr_bin_next - afifo_ptr_pkg::gray2bin(rd_ptr_sync_i);

    always_ff @(posedge wr_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_bin   <= '0;
            wr_gray  <= '0;
            full_o   <= 1'b0;
            a_full_o <= 1'b0;
        end else begin
            wr_bin   <= wr_bin_next;
            wr_gray  <= wr_gray_next;
            full_o   <= (wr_gray_next == rd_ptr_wrapped);
            a_full_o <= (level_next >= AFULL_LEVEL);
        end
    end

    assign wr_addr_o     = wr_bin[ADDR_WIDTH-1:0];
    assign wr_ptr_gray_o = wr_gray;

    // The read side synchronizer relies on single-bit steps.
    a_wr_gray_step: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
        $countones(wr_gray ^ $past(wr_gray)) <= 1);

    // The level never passes the depth, so no push lands on a full FIFO.
    a_no_write_full: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
        level_next <= (ADDR_WIDTH + 1)'(`AFIFO_DEPTH));

endmodule

`default_nettype wire

// File: src/afifo_sync_stages.sv
// Flop chain for a gray-coded pointer entering another clock domain.
// Only one bit of data_i may change at a time.
`timescale 1ns/1ns
`default_nettype none

module afifo_sync_stages #(
    parameter int DATA_WIDTH = 5,
    parameter int STAGES     = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [DATA_WIDTH-1:0] data_o
);

    logic [DATA_WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= data_i; // First flop may go metastable.
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign data_o = sync_q[STAGES-1];

    if (STAGES < 2) begin : g_stages_check
        $error("afifo_sync_stages needs at least two stages.");
    end

endmodule

`default_nettype wire

// File: src/afifo_mem_pkg.sv
// Storage types for the FIFO memory.
`default_nettype none

package afifo_mem_pkg;

    // Selects the RAM resource that synthesis infers.
    typedef enum logic {
        MEM_BLOCK,
        MEM_DISTRIBUTED
    } mem_style_e;

endpackage

`default_nettype wire

// File: src/afifo_ptr_pkg.sv
// Pointer helpers shared by the write and read pointer blocks.
// Pointer width follows AFIFO_DEPTH and is one bit wider than the address.
`default_nettype none

`include "afifo_settings.svh"

package afifo_ptr_pkg;

    localparam int PTR_WIDTH = $clog2(`AFIFO_DEPTH) + 1;

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all gray bits at and above it.
    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

// File: src/afifo_settings.svh
// Build-time settings for the dual-clock FIFO.
// AFIFO_DEPTH must be a power of two and at least 4.
// Both margins must stay below AFIFO_DEPTH.
`ifndef AFIFO_SETTINGS_SVH
`define AFIFO_SETTINGS_SVH

// Data word width in bits.
`define AFIFO_WIDTH 32

// Number of entries.
`define AFIFO_DEPTH 16

// Synchronizer flops per crossing. Two is the minimum.
`define AFIFO_CDC_STAGES 2

`define AFIFO_AFULL_MARGIN 2  // Almost full at depth minus this level.
`define AFIFO_AEMPTY_MARGIN 2 // Almost empty at or below this level.

`endif
